/* dv/tb_clock_gen.sv */
// Free-running 40 ns clock that starts low; reset is driven by the testbench top
module tb_clock_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

/* dv/tb_us_packer.sv */
// Self-checking testbench; nr_rx changes only across resets, grants follow after 0 to 3 idle cycles
module tb_us_packer;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 20000;  // Cycles per wait

  logic                   clk;
  logic                   discover_rst = 1'b1;
  logic                   run = 1'b0;
  logic [1:0]             nr_rx = 2'd0;
  logic [47:0]            mac = 48'h02_5e_c1_a0_33_9d;
  logic                   discover_rqst = 1'b0;
  logic                   in_valid = 1'b0;
  us_packer_pkg::sample_t in_data = '0;
  logic                   in_mic = 1'b0;
  logic                   in_ready;
  logic [39:0]            resp = '0;
  logic                   resp_rqst;
  logic                   tx_request;
  logic                   tx_enable = 1'b0;
  us_packer_pkg::tx_len_t tx_length;
  logic [7:0]             tx_data;
  logic                   tx_valid;

  integer      seed = 32'hc5fe;
  logic [24:0] ref_q[$];  // {mic, sample} in acceptance order
  logic [7:0]  frame[int'(us_packer_pkg::DATA_LEN)];
  int          rx_cnt = 0;
  int          frame_len = 0;
  int          toggles = 0;
  logic        resp_q = 1'b0;
  int          gnt_delay = 2;
  logic        grant_hold = 1'b0;
  int          acc_cnt = 0;
  int          disc_pending = 0;
  logic [7:0]  disc_status = 8'h02;
  logic [31:0] exp_seq = '0;
  event        frame_done;

  tb_clock_gen u_clk (.clk(clk));

  us_packer_top u_dut (.*);

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [47:0] exp_v,
                                 input logic [47:0] act_v);
    stop_on_error($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", sig, exp_v, act_v));
  endtask

  task automatic check_byte(input int idx, input logic [7:0] exp_b);
    if (frame[idx] !== exp_b) begin
      report_mismatch($sformatf("tx_data byte %0d", idx), exp_b, frame[idx]);
    end
  endtask

  task automatic check_disc_frame();
    int k;
    if (disc_pending == 0) stop_on_error("discovery reply sent without a request");
    check_byte(0, 8'hef);
    check_byte(1, 8'hfe);
    check_byte(2, disc_status);
    for (k = 0; k < 6; k++) check_byte(3 + k, mac[47 - 8*k -: 8]);
    check_byte(9, us_packer_pkg::FW_VERSION);
    check_byte(10, us_packer_pkg::BOARD_ID);
    for (k = 11; k < us_packer_pkg::DISC_LEN; k++) check_byte(k, 8'h00);
    if (toggles != 0) report_mismatch("resp_rqst toggles", 0, toggles);
    disc_pending--;
  endtask

  task automatic check_data_frame();
    int k;
    int sub;
    int pos;
    int base;
    int round_len;
    logic [24:0] smp;
    logic mic0;
    round_len = 3 * (nr_rx + 1) + 2;  // Samples plus two mic bytes
    check_byte(0, 8'hef);
    check_byte(1, 8'hfe);
    check_byte(2, 8'h01);
    check_byte(3, 8'h06);
    for (k = 0; k < 4; k++) check_byte(4 + k, exp_seq[31 - 8*k -: 8]);
    for (sub = 0; sub < 2; sub++) begin
      base = 8 + sub * us_packer_pkg::SUBFRAME_BYTES;
      for (k = 0; k < 3; k++) check_byte(base + k, 8'h7f);
      for (k = 0; k < 5; k++) check_byte(base + 3 + k, resp[39 - 8*k -: 8]);
      pos = base + 8;
      // Whole rounds only
      while (base + us_packer_pkg::SUBFRAME_BYTES - pos >= round_len) begin
        for (k = 0; k <= nr_rx; k++) begin
          if (ref_q.size() == 0) stop_on_error("data frame holds more samples than were sent");
          smp = ref_q.pop_front();
          if (k == 0) mic0 = smp[24];
          check_byte(pos, smp[23:16]);
          check_byte(pos + 1, smp[15:8]);
          check_byte(pos + 2, smp[7:0]);
          pos += 3;
        end
        check_byte(pos, 8'h00);
        check_byte(pos + 1, {7'd0, mic0});
        pos += 2;
      end
      for (; pos < base + us_packer_pkg::SUBFRAME_BYTES; pos++) check_byte(pos, 8'h00);
    end
    if (toggles != 2) report_mismatch("resp_rqst toggles", 2, toggles);
    exp_seq++;
  endtask

  a_idle_after_reset: assert property (@(posedge clk)
    $fell(discover_rst) |-> !tx_request && !tx_valid && !resp_rqst && !in_ready ##1 in_ready)
    else stop_on_error("outputs not idle after reset or in_ready did not rise");

  a_grant_starts_frame: assert property (@(posedge clk) disable iff (discover_rst)
    tx_request && tx_enable |=> !tx_request && tx_valid)
    else stop_on_error("grant did not start the frame on the next cycle");

  // Network side, bytes and grants
  always @(negedge clk) begin
    if (discover_rst) begin
      rx_cnt = 0;
      resp_q = 1'b0;
      tx_enable = 1'b0;
    end else begin
      if (tx_valid) begin
        if (rx_cnt == 0) begin
          frame_len = tx_length;
          toggles = 0;
          if (!(frame_len inside {us_packer_pkg::DISC_LEN, us_packer_pkg::DATA_LEN})) begin
            report_mismatch("tx_length", us_packer_pkg::DATA_LEN, tx_length);
          end
        end
        frame[rx_cnt] = tx_data;
        rx_cnt++;
        if (rx_cnt == frame_len) begin
          rx_cnt = 0;
          -> frame_done;
        end
      end else if (rx_cnt != 0) begin
        stop_on_error("tx_valid dropped before the frame was complete");
      end
      if (resp_rqst !== resp_q) toggles++;
      resp_q = resp_rqst;
      if (tx_enable && !tx_request) begin
        tx_enable = 1'b0;
        gnt_delay = $unsigned($random(seed)) % 4;
      end else if (tx_request && !grant_hold) begin
        if (gnt_delay == 0) tx_enable = 1'b1;
        else gnt_delay--;
      end
    end
  end

  always @(frame_done) begin
    if (frame_len == us_packer_pkg::DISC_LEN) check_disc_frame();
    else check_data_frame();
  end

  task automatic apply_reset();
    run = 1'b0;
    discover_rst = 1'b1;
    repeat (4) @(negedge clk);
    discover_rst = 1'b0;
    ref_q.delete();
    exp_seq = '0;
    repeat (2) @(negedge clk);  // in_ready is up by now
  endtask

  task automatic send_rounds(input int rounds);
    int i;
    int t;
    for (i = 0; i < rounds * (nr_rx + 1); i++) begin
      in_valid = 1'b1;
      in_data = us_packer_pkg::sample_t'($random(seed));
      in_mic = 1'($random(seed));
      t = 0;
      while (!in_ready) begin
        @(negedge clk);
        t++;
        if (t > TIMEOUT) stop_on_error("in_ready stayed low, sample never accepted");
      end
      ref_q.push_back({in_mic, in_data});  // Taken at the next rising edge
      acc_cnt++;
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic settle_and_check();
    int idle;
    int t;
    idle = 0;
    t = 0;
    while (idle < 8) begin
      @(negedge clk);
      t++;
      idle = (tx_request || tx_valid) ? 0 : idle + 1;
      if (t > TIMEOUT) stop_on_error("packer never went idle");
    end
    if (disc_pending != 0) stop_on_error("discovery request got no reply");
    if (ref_q.size() >= us_packer_pkg::FRAME_WORDS) begin
      stop_on_error($sformatf("%0d samples buffered but no data frame sent", ref_q.size()));
    end
  endtask

  task automatic request_discovery();
    disc_status = run ? 8'h03 : 8'h02;
    disc_pending++;
    discover_rqst = 1'b1;
    @(negedge clk);
    discover_rqst = 1'b0;
    settle_and_check();
  endtask

  initial begin
    int n;
    int t;
    apply_reset();
    request_discovery();
    for (n = 0; n < 4; n++) begin
      apply_reset();
      nr_rx = 2'(n);
      resp = {8'($random(seed)), 32'($random(seed))};
      run = 1'b1;
      send_rounds(3 * us_packer_pkg::FRAME_WORDS / (n + 1));
      settle_and_check();
      request_discovery();  // Status 03 while running
      run = 1'b0;
      exp_seq = '0;
      repeat (2) @(negedge clk);
      run = 1'b1;
      send_rounds(us_packer_pkg::FRAME_WORDS / (n + 1));
      settle_and_check();
      if (exp_seq == 0) stop_on_error("no data frame after run was raised again");
    end
    // Back-pressure with grants withheld
    apply_reset();
    nr_rx = 2'd3;
    grant_hold = 1'b1;
    acc_cnt = 0;
    run = 1'b1;
    fork
      send_rounds(200);
      begin
        t = 0;
        while (in_ready) begin
          @(negedge clk);
          t++;
          if (t > TIMEOUT) stop_on_error("in_ready never fell with grants withheld");
        end
        if (acc_cnt != us_packer_pkg::BUF_DEPTH) begin
          report_mismatch("accepted samples", us_packer_pkg::BUF_DEPTH, acc_cnt);
        end
        @(posedge clk);
        grant_hold = 1'b0;
      end
    join
    settle_and_check();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* source/us_frame_packer.sv */
// Serializes discovery replies and 1032-byte data frames; data starts only with a full frame buffered
module us_frame_packer (
  input  logic                     clk,
  input  logic                     discover_rst,
  input  logic                     run,
  input  logic [47:0]              mac,
  input  logic                     discover_rqst,
  input  us_packer_pkg::buf_word_t rd_data,
  input  us_packer_pkg::fill_t     fill,
  output logic                     rd_en,
  input  logic [39:0]              resp,
  output logic                     resp_rqst,
  output logic                     tx_request,
  input  logic                     tx_enable,
  output us_packer_pkg::tx_len_t   tx_length,
  output logic [7:0]               tx_data,
  output logic                     tx_valid
);

  us_packer_pkg::pack_state_t state;
  us_packer_pkg::pack_state_t state_nx;

  us_packer_pkg::tx_len_t cnt;  // Bytes left after the current one
  us_packer_pkg::tx_len_t cnt_nx;
  us_packer_pkg::tx_len_t len_nx;
  us_packer_pkg::seq_t    seq;
  us_packer_pkg::sample_t head_smp;

  logic [1:0] sub_sel;  // Byte within a sample or mic pair
  logic [1:0] sub_sel_nx;
  logic [4:0] round_bytes;
  logic [4:0] round_nx;
  logic       mic_q;
  logic       mic_nx;
  logic [7:0] byte_nx;
  logic       valid_nx;
  logic       resp_toggle;
  logic       seq_inc;
  logic       disc_pend;
  logic       disc_take;
  logic [5:0] disc_idx;
  logic [2:0] hdr_idx;
  logic       more_sub;

  logic [us_packer_pkg::SUB_AW-1:0] sub_left;
  logic [us_packer_pkg::SUB_AW-1:0] sub_idx;

  assign head_smp = rd_data[us_packer_pkg::MIC_BIT-1:0];
  assign disc_idx = 6'(us_packer_pkg::DISC_LEN - us_packer_pkg::tx_len_t'(1) - cnt);
  assign hdr_idx  = 3'(us_packer_pkg::DATA_LEN - us_packer_pkg::tx_len_t'(1) - cnt);
  assign sub_left = cnt[us_packer_pkg::SUB_AW-1:0];
  assign more_sub = cnt[us_packer_pkg::SUB_AW];  // Second subframe still ahead
  assign sub_idx  = us_packer_pkg::SUB_AW'(us_packer_pkg::SUBFRAME_BYTES - 1) - sub_left;

  assign tx_request = (state == us_packer_pkg::DISC_REQ) || (state == us_packer_pkg::DATA_REQ);

  always_comb begin
    state_nx    = state;
    cnt_nx      = cnt - us_packer_pkg::tx_len_t'(1);
    len_nx      = tx_length;
    sub_sel_nx  = sub_sel;
    round_nx    = round_bytes;
    mic_nx      = mic_q;
    byte_nx     = 8'h00;
    valid_nx    = 1'b1;
    resp_toggle = 1'b0;
    seq_inc     = 1'b0;
    disc_take   = 1'b0;
    rd_en       = 1'b0;

    case (state)
      us_packer_pkg::IDLE: begin
        valid_nx = 1'b0;
        cnt_nx   = cnt;
        if (disc_pend) begin  // Discovery wins over data
          state_nx  = us_packer_pkg::DISC_REQ;
          len_nx    = us_packer_pkg::DISC_LEN;
          disc_take = 1'b1;
        end else if (run && fill >= us_packer_pkg::fill_t'(us_packer_pkg::FRAME_WORDS)) begin
          state_nx = us_packer_pkg::DATA_REQ;
          len_nx   = us_packer_pkg::DATA_LEN;
        end
      end

      us_packer_pkg::DISC_REQ: begin
        cnt_nx   = us_packer_pkg::DISC_LEN - us_packer_pkg::tx_len_t'(2);
        byte_nx  = 8'hef;
        valid_nx = tx_enable;
        if (tx_enable) begin
          state_nx = us_packer_pkg::DISC_BODY;
        end
      end

      us_packer_pkg::DISC_BODY: begin
        case (disc_idx)
          6'd1:    byte_nx = 8'hfe;
          6'd2:    byte_nx = run ? 8'h03 : 8'h02;
          6'd3:    byte_nx = mac[47:40];
          6'd4:    byte_nx = mac[39:32];
          6'd5:    byte_nx = mac[31:24];
          6'd6:    byte_nx = mac[23:16];
          6'd7:    byte_nx = mac[15:8];
          6'd8:    byte_nx = mac[7:0];
          6'd9:    byte_nx = us_packer_pkg::FW_VERSION;
          6'd10:   byte_nx = us_packer_pkg::BOARD_ID;
          default: byte_nx = 8'h00;
        endcase
        if (cnt == '0) begin
          state_nx = us_packer_pkg::IDLE;
        end
      end

      us_packer_pkg::DATA_REQ: begin
        cnt_nx   = us_packer_pkg::DATA_LEN - us_packer_pkg::tx_len_t'(2);
        byte_nx  = 8'hef;
        valid_nx = tx_enable;
        if (tx_enable) begin
          state_nx = us_packer_pkg::DATA_HDR;
        end
      end

      us_packer_pkg::DATA_HDR: begin
        case (hdr_idx)
          3'd1:    byte_nx = 8'hfe;
          3'd2:    byte_nx = 8'h01;
          3'd3:    byte_nx = 8'h06;
          3'd4:    byte_nx = seq[31:24];
          3'd5:    byte_nx = seq[23:16];
          3'd6:    byte_nx = seq[15:8];
          3'd7:    byte_nx = seq[7:0];
          default: byte_nx = 8'h00;
        endcase
        if (hdr_idx == 3'd7) begin
          state_nx = us_packer_pkg::SYNC_RESP;
        end
      end

      us_packer_pkg::SYNC_RESP: begin
        round_nx = 5'd0;
        case (sub_idx)
          9'd0, 9'd1, 9'd2: byte_nx = 8'h7f;
          9'd3:    byte_nx = resp[39:32];
          9'd4:    byte_nx = resp[31:24];
          9'd5:    byte_nx = resp[23:16];
          9'd6:    byte_nx = resp[15:8];
          9'd7:    byte_nx = resp[7:0];
          default: byte_nx = 8'h00;
        endcase
        if (sub_idx == 9'd7) begin
          resp_toggle = 1'b1;
          sub_sel_nx  = 2'd0;
          state_nx    = us_packer_pkg::RX_BYTES;
        end
      end

      us_packer_pkg::RX_BYTES: begin
        round_nx = round_bytes + 5'd1;
        case (sub_sel)
          2'd0: begin
            byte_nx = head_smp[23:16];
            if (round_bytes == 5'd0) begin
              mic_nx = rd_data[us_packer_pkg::MIC_BIT];  // Mic bit of first sample
            end
          end
          2'd1:    byte_nx = head_smp[15:8];
          default: byte_nx = head_smp[7:0];
        endcase
        if (sub_sel == 2'd2) begin
          rd_en      = 1'b1;
          sub_sel_nx = 2'd0;
          if (rd_data[us_packer_pkg::EOR_BIT]) begin
            state_nx = us_packer_pkg::MIC_BYTES;
          end
        end else begin
          sub_sel_nx = sub_sel + 2'd1;
        end
      end

      us_packer_pkg::MIC_BYTES: begin
        if (sub_sel == 2'd0) begin
          byte_nx    = 8'h00;
          round_nx   = round_bytes + 5'd1;
          sub_sel_nx = 2'd1;
        end else begin
          byte_nx    = {7'd0, mic_q};
          round_nx   = 5'd0;
          sub_sel_nx = 2'd0;
          // Room for another round of the same length?
          if (sub_left > {4'd0, round_bytes}) begin
            state_nx = us_packer_pkg::RX_BYTES;
          end else begin
            state_nx = us_packer_pkg::PAD;
          end
        end
      end

      us_packer_pkg::PAD: byte_nx = 8'h00;

      default: state_nx = us_packer_pkg::IDLE;
    endcase

    // Subframe boundary
    if ((state inside {us_packer_pkg::RX_BYTES, us_packer_pkg::MIC_BYTES, us_packer_pkg::PAD})
        && sub_left == '0) begin
      state_nx   = more_sub ? us_packer_pkg::SYNC_RESP : us_packer_pkg::IDLE;
      sub_sel_nx = 2'd0;
      seq_inc    = !more_sub;
    end
  end

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      state       <= us_packer_pkg::IDLE;
      cnt         <= '0;
      sub_sel     <= 2'd0;
      round_bytes <= 5'd0;
      tx_valid    <= 1'b0;
      tx_length   <= '0;
      resp_rqst   <= 1'b0;
      disc_pend   <= 1'b0;
    end else begin
      state       <= state_nx;
      cnt         <= cnt_nx;
      sub_sel     <= sub_sel_nx;
      round_bytes <= round_nx;
      tx_valid    <= valid_nx;
      tx_length   <= len_nx;
      if (resp_toggle) begin
        resp_rqst <= ~resp_rqst;
      end
      if (discover_rqst) begin
        disc_pend <= 1'b1;
      end else if (disc_take) begin
        disc_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    tx_data <= byte_nx;
    mic_q   <= mic_nx;
  end

  always_ff @(posedge clk) begin
    if (discover_rst || !run) begin
      seq <= '0;
    end else if (seq_inc) begin
      seq <= seq + 32'd1;
    end
  end

  // Bytes flow only after a grant and stay contiguous to the end of the frame
  a_tx_in_frame: assert property (@(posedge clk) disable iff (discover_rst)
    tx_valid |-> !tx_request && ($past(tx_valid) || $past(tx_request && tx_enable)))
    else $error("tx_valid outside a granted frame");

endmodule

/* source/us_packer_pkg.sv */
// Widths, buffer word layout and frame constants; FRAME_WORDS assumes at most four receivers
package us_packer_pkg;

  typedef logic [23:0] sample_t;    // One receiver I/Q word
  typedef logic [25:0] buf_word_t;  // {eor, mic, sample}
  typedef logic [9:0]  fill_t;      // 0 to BUF_DEPTH
  typedef logic [31:0] seq_t;
  typedef logic [10:0] tx_len_t;

  localparam int BUF_DEPTH = 512;
  localparam int BUF_AW    = $clog2(BUF_DEPTH);

  // Tag bits above the sample in buf_word_t
  localparam int MIC_BIT = 24;
  localparam int EOR_BIT = 25;

  // Worst case is four receivers, 36 rounds per subframe
  localparam int FRAME_WORDS = 288;

  localparam int SUBFRAME_BYTES = 512;
  localparam int SUB_AW         = $clog2(SUBFRAME_BYTES);

  localparam tx_len_t DATA_LEN = 11'd1032;
  localparam tx_len_t DISC_LEN = 11'd60;

  localparam logic [7:0] FW_VERSION = 8'h48;
  localparam logic [7:0] BOARD_ID   = 8'h06;

  typedef enum logic [3:0] {
    IDLE,
    DISC_REQ,   // Waiting for grant of a discovery reply
    DISC_BODY,
    DATA_REQ,   // Waiting for grant of a data frame
    DATA_HDR,
    SYNC_RESP,  // 7F 7F 7F plus response word
    RX_BYTES,
    MIC_BYTES,
    PAD
  } pack_state_t;

endpackage

/* source/us_packer_top.sv */
// Upstream path from receiver samples to the UDP byte port; nr_rx must not change while run is high
module us_packer_top (
  input  logic                   clk,
  input  logic                   discover_rst,
  input  logic                   run,
  input  logic [1:0]             nr_rx,
  input  logic [47:0]            mac,
  input  logic                   discover_rqst,
  input  logic                   in_valid,
  input  us_packer_pkg::sample_t in_data,
  input  logic                   in_mic,
  output logic                   in_ready,
  input  logic [39:0]            resp,
  output logic                   resp_rqst,
  output logic                   tx_request,
  input  logic                   tx_enable,
  output us_packer_pkg::tx_len_t tx_length,
  output logic [7:0]             tx_data,
  output logic                   tx_valid
);

  logic                     wr_en;
  us_packer_pkg::buf_word_t wr_data;
  logic                     credit_ret;
  logic                     rd_en;
  us_packer_pkg::buf_word_t rd_data;
  us_packer_pkg::fill_t     fill;

  us_round_framer u_framer (
    .clk(clk),
    .discover_rst(discover_rst),
    .run(run),
    .nr_rx(nr_rx),
    .in_valid(in_valid),
    .in_data(in_data),
    .in_mic(in_mic),
    .in_ready(in_ready),
    .wr_en(wr_en),
    .wr_data(wr_data),
    .credit_ret(credit_ret)
  );

  us_sample_fifo u_fifo (
    .clk(clk),
    .discover_rst(discover_rst),
    .wr_en(wr_en),
    .wr_data(wr_data),
    .rd_en(rd_en),
    .rd_data(rd_data),
    .fill(fill),
    .credit_ret(credit_ret)
  );

  us_frame_packer u_packer (
    .clk(clk),
    .discover_rst(discover_rst),
    .run(run),
    .mac(mac),
    .discover_rqst(discover_rqst),
    .rd_data(rd_data),
    .fill(fill),
    .rd_en(rd_en),
    .resp(resp),
    .resp_rqst(resp_rqst),
    .tx_request(tx_request),
    .tx_enable(tx_enable),
    .tx_length(tx_length),
    .tx_data(tx_data),
    .tx_valid(tx_valid)
  );

endmodule

/* source/us_round_framer.sv */
// Tags samples with round position; nr_rx must stay fixed while run is high, index restarts on run low
module us_round_framer (
  input  logic                     clk,
  input  logic                     discover_rst,
  input  logic                     run,
  input  logic [1:0]               nr_rx,
  input  logic                     in_valid,
  input  us_packer_pkg::sample_t   in_data,
  input  logic                     in_mic,
  output logic                     in_ready,
  output logic                     wr_en,
  output us_packer_pkg::buf_word_t wr_data,
  input  logic                     credit_ret
);

  logic                 take;
  logic                 last_rx;
  logic [1:0]           rx_idx;
  us_packer_pkg::fill_t credits;
  us_packer_pkg::fill_t credits_nx;

  assign take    = in_valid & in_ready;
  assign last_rx = (rx_idx == nr_rx);

  // One credit per buffer slot
  always_comb begin
    credits_nx = credits;
    if (take && !credit_ret) begin
      credits_nx = credits - us_packer_pkg::fill_t'(1);
    end else if (credit_ret && !take) begin
      credits_nx = credits + us_packer_pkg::fill_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      credits  <= us_packer_pkg::fill_t'(us_packer_pkg::BUF_DEPTH);
      in_ready <= 1'b0;
      wr_en    <= 1'b0;
      rx_idx   <= 2'd0;
    end else begin
      credits  <= credits_nx;
      in_ready <= (credits_nx != '0);  // Tracks credits exactly
      wr_en    <= take;
      if (!run) begin
        rx_idx <= 2'd0;
      end else if (take) begin
        rx_idx <= last_rx ? 2'd0 : rx_idx + 2'd1;
      end
    end
  end

  // Layout must match MIC_BIT and EOR_BIT
  always_ff @(posedge clk) begin
    if (take) begin
      wr_data <= {last_rx, in_mic, in_data};
    end
  end

  // Buffer must return no more credits than were spent
  a_credit_range: assert property (@(posedge clk) disable iff (discover_rst)
    credits <= us_packer_pkg::fill_t'(us_packer_pkg::BUF_DEPTH))
    else $error("framer credit count out of range: %0d", credits);

  // A credit in flight means an entry was written earlier
  a_credit_after_write: assert property (@(posedge clk) disable iff (discover_rst)
    credit_ret |-> credits != us_packer_pkg::fill_t'(us_packer_pkg::BUF_DEPTH))
    else $error("credit returned with all credits held");

endmodule

/* source/us_sample_fifo.sv */
// Sample buffer with asynchronous head read; writer must respect credits, reader must check fill
module us_sample_fifo (
  input  logic                     clk,
  input  logic                     discover_rst,
  input  logic                     wr_en,
  input  us_packer_pkg::buf_word_t wr_data,
  input  logic                     rd_en,
  output us_packer_pkg::buf_word_t rd_data,
  output us_packer_pkg::fill_t     fill,
  output logic                     credit_ret
);

  us_packer_pkg::buf_word_t mem [us_packer_pkg::BUF_DEPTH];

  logic [us_packer_pkg::BUF_AW-1:0] wr_ptr;
  logic [us_packer_pkg::BUF_AW-1:0] rd_ptr;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_ptr];  // First-word view

  always_ff @(posedge clk) begin
    if (discover_rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      credit_ret <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at BUF_DEPTH
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   fill <= fill + us_packer_pkg::fill_t'(1);
        2'b01:   fill <= fill - us_packer_pkg::fill_t'(1);
        default: fill <= fill;
      endcase
      credit_ret <= rd_en;  // Slot is free again
    end
  end

  // Credit flow upstream keeps writes out of a full buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (discover_rst)
    wr_en |-> fill != us_packer_pkg::fill_t'(us_packer_pkg::BUF_DEPTH))
    else $error("write into full sample buffer");

  // Packer only starts frames with enough words buffered
  a_no_underflow: assert property (@(posedge clk) disable iff (discover_rst)
    rd_en |-> fill != '0)
    else $error("pop from empty sample buffer");

endmodule

/* us_packer_top.f */
source/us_packer_pkg.sv
source/us_round_framer.sv
source/us_sample_fifo.sv
source/us_frame_packer.sv
source/us_packer_top.sv
dv/tb_clock_gen.sv
dv/tb_us_packer.sv
